/* esp_cmd_parser.sv */
`timescale 1ns/1ps
`include "trs_io_consts.svh"

module esp_cmd_parser (
  input  logic                   clk,
  input  logic                   cass_out_sel_n,
  input  logic [7:0]             byte_in,
  input  logic                   byte_valid,
  input  logic [7:0]             flash_rdata,
  output logic [7:0]             reply,
  output esp_link_pkg::esp_cmd_t cmd,
  output logic                   cmd_valid,
  output esp_link_pkg::led_rgb_t led,
  output logic                   err_led
);

  import esp_link_pkg::*;

  parser_state_e state;
  esp_op_e       pend_op;
  logic [7:0]    getter_reply;

  // reply byte for the opcodes that take no argument
  always_comb begin
    case (byte_in)
      get_cookie:  getter_reply = `TRS_IO_COOKIE;
      get_version: getter_reply = `TRS_IO_VERSION;
      default:     getter_reply = flash_rdata;
    endcase
  end

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      state     <= idle;
      pend_op   <= get_cookie;
      reply     <= 8'h00;
      cmd       <= '0;
      cmd_valid <= 1'b0;
      led       <= '0;
      err_led   <= 1'b0;
    end else begin
      cmd_valid <= 1'b0;
      if (byte_valid) begin
        case (state)
          idle: begin
            case (byte_in)
              get_cookie, get_version, get_spi_data: begin
                cmd.op    <= esp_op_e'(byte_in);
                cmd.param <= 8'h00;
                cmd_valid <= 1'b1;
                reply     <= getter_reply;
              end
              set_led, set_spi_ctrl_reg, set_spi_data: begin
                pend_op <= esp_op_e'(byte_in);
                state   <= read_param;
              end
              // unknown opcode leaves the error lit until reset
              default: begin
                err_led <= 1'b1;
              end
            endcase
          end
          read_param: begin
            cmd.op    <= pend_op;
            cmd.param <= byte_in;
            cmd_valid <= 1'b1;
            if (pend_op == set_led) begin
              led <= led_rgb_t'(byte_in[2:0]);
            end
            state <= idle;
          end
          default: begin
            state <= idle;
          end
        endcase
      end
    end
  end

  a_state_legal: assert property (
    @(posedge clk) disable iff (!cass_out_sel_n)
    state inside {idle, read_param}
  );

endmodule

/* esp_link_pkg.sv */
package esp_link_pkg;

  // opcode values as the esp firmware sends them
  typedef enum logic [7:0] {
    get_cookie       = 8'd0,
    get_version      = 8'd15,
    set_led          = 8'd26,
    set_spi_ctrl_reg = 8'd29,
    set_spi_data     = 8'd30,
    get_spi_data     = 8'd31
  } esp_op_e;

  // idle waits for an opcode, read_param for the one setter argument
  typedef enum logic {
    idle       = 1'b0,
    read_param = 1'b1
  } parser_state_e;

  // one executed command
  typedef struct packed {
    esp_op_e    op;
    logic [7:0] param;
  } esp_cmd_t;

  // red sits in bit 0, as in the set_led argument
  typedef struct packed {
    logic blue;
    logic green;
    logic red;
  } led_rgb_t;

endpackage

/* esp_spi_slave.sv */
`timescale 1ns/1ps
`include "trs_io_consts.svh"

module esp_spi_slave (
  input  logic       clk,
  input  logic       cass_out_sel_n,
  input  logic       cs_n,
  input  logic       sck,
  input  logic       mosi,
  output logic       miso,
  input  logic [7:0] reply,
  output logic [7:0] byte_in,
  output logic       byte_valid
);

  logic [`SYNC_DEPTH-1:0] cs_n_sync;
  logic [`SYNC_DEPTH-1:0] sck_sync;
  logic [`SYNC_DEPTH-1:0] mosi_sync;
  logic                   cs_active;
  logic                   sck_rise;
  logic                   sck_fall;
  logic [2:0]             bit_cnt;
  logic [7:0]             tx_shift;

  // oldest stage is the one we act on
  assign cs_active = ~cs_n_sync[`SYNC_DEPTH-1];
  assign sck_rise  = sck_sync[`SYNC_DEPTH-2] & ~sck_sync[`SYNC_DEPTH-1];
  assign sck_fall  = ~sck_sync[`SYNC_DEPTH-2] & sck_sync[`SYNC_DEPTH-1];

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      cs_n_sync  <= '1;
      sck_sync   <= '0;
      mosi_sync  <= '0;
      bit_cnt    <= 3'd0;
      byte_in    <= 8'h00;
      byte_valid <= 1'b0;
      tx_shift   <= 8'h00;
    end else begin
      cs_n_sync  <= {cs_n_sync[`SYNC_DEPTH-2:0], cs_n};
      sck_sync   <= {sck_sync[`SYNC_DEPTH-2:0], sck};
      mosi_sync  <= {mosi_sync[`SYNC_DEPTH-2:0], mosi};
      byte_valid <= 1'b0;
      if (!cs_active) begin
        bit_cnt <= 3'd0;
      end else begin
        // msb first on rising sck
        if (sck_rise) begin
          bit_cnt <= bit_cnt + 3'd1;
          byte_in <= {byte_in[6:0], mosi_sync[`SYNC_DEPTH-1]};
          if (bit_cnt == 3'd7) begin
            byte_valid <= 1'b1;
          end
        end
        // first falling edge of a byte picks up the reply
        if (sck_fall) begin
          if (bit_cnt == 3'd1) begin
            tx_shift <= reply;
          end else begin
            tx_shift <= {tx_shift[6:0], 1'b0};
          end
        end
      end
    end
  end

  assign miso = cs_active ? tx_shift[7] : 1'b0;

  // a byte only completes inside a chip select window
  a_valid_in_frame: assert property (
    @(posedge clk) disable iff (!cass_out_sel_n)
    $rose(byte_valid) |-> $past(cs_active) && $past(sck_rise)
  );

endmodule

/* flash_arbiter.sv */
`timescale 1ns/1ps

module flash_arbiter (
  input  logic                   clk,
  input  logic                   cass_out_sel_n,
  input  flash_pkg::flash_req_t  z80_req,
  input  esp_link_pkg::esp_cmd_t esp_cmd,
  input  logic                   esp_cmd_valid,
  input  logic                   flash_busy,
  output flash_pkg::flash_req_t  grant
);

  import esp_link_pkg::*;
  import flash_pkg::*;

  arb_state_e state;
  logic [7:0] held_data;
  logic       esp_ctrl;
  logic       esp_start;
  logic       z80_go;
  logic       z80_use;
  logic       lane_free;
  logic       esp_ctrl_go;
  logic       pend_go;
  logic       esp_go;

  assign esp_ctrl  = esp_cmd_valid && (esp_cmd.op == set_spi_ctrl_reg);
  assign esp_start = esp_cmd_valid && (esp_cmd.op == set_spi_data);

  // z80 start while busy is simply lost
  assign z80_go  = z80_req.start & ~flash_busy;
  assign z80_use = z80_req.ctrl_wr | z80_go;

  // esp ctrl write loses a same-clock collision with the z80
  assign esp_ctrl_go = esp_ctrl & ~z80_use;

  // data lane free of z80 traffic and master idle
  assign lane_free = ~flash_busy & ~z80_req.start & ~z80_req.ctrl_wr;
  assign pend_go   = (state == arb_pending) & lane_free & ~esp_ctrl;
  assign esp_go    = esp_start & lane_free & (state == arb_idle);

  assign grant.ctrl_wr = z80_req.ctrl_wr | esp_ctrl_go;
  assign grant.start   = z80_go | pend_go | esp_go;
  assign grant.data    = z80_use ? z80_req.data : (pend_go ? held_data : esp_cmd.param);

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      state     <= arb_idle;
      held_data <= 8'h00;
    end else if (esp_start && !esp_go) begin
      // park it, a newer esp byte replaces the old one
      state     <= arb_pending;
      held_data <= esp_cmd.param;
    end else if (pend_go) begin
      state <= arb_idle;
    end
  end

  // a granted start always finds the master idle and makes it busy
  a_start_when_idle: assert property (
    @(posedge clk) disable iff (!cass_out_sel_n)
    grant.start |-> !flash_busy ##1 flash_busy
  );

endmodule

/* flash_pkg.sv */
package flash_pkg;

  // a control register write and/or a byte transfer start
  typedef struct packed {
    logic       ctrl_wr;
    logic       start;
    logic [7:0] data;
  } flash_req_t;

  // pins toward the configuration flash
  typedef struct packed {
    logic cs_n;
    logic sck;
    logic si;
  } flash_pins_t;

  // z80 i/o cycle as seen by the port decoder
  typedef struct packed {
    logic [7:0] addr;
    logic       rd_n;
    logic       wr_n;
    logic [7:0] wdata;
  } z80_io_t;

  typedef enum logic {
    arb_idle    = 1'b0,
    arb_pending = 1'b1
  } arb_state_e;

endpackage

/* flash_spi_master.sv */
`timescale 1ns/1ps
`include "trs_io_consts.svh"

module flash_spi_master (
  input  logic                   clk,
  input  logic                   cass_out_sel_n,
  input  flash_pkg::flash_req_t  grant,
  input  logic                   so,
  output flash_pkg::flash_pins_t pins,
  output logic                   busy,
  output logic [7:0]             rdata
);

  // bit 7 of the control register selects the flash
  logic       cs_sel;
  logic [7:0] shift;
  logic [7:0] count;
  logic       si_q;

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      cs_sel <= 1'b0;
    end else if (grant.ctrl_wr) begin
      cs_sel <= grant.data[7];
    end
  end

  // count[3] is sck, count[7] is busy
  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      count <= 8'h00;
      shift <= 8'h00;
      si_q  <= 1'b0;
    end else if (count[7]) begin
      count <= count + 8'd1;
      if (count[3:0] == 4'h7) begin
        // sck rises on this edge, sample so
        shift <= {shift[6:0], so};
      end else if (count[3:0] == 4'hF) begin
        // next low half, put the next bit out
        si_q <= (count == 8'hFF) ? 1'b0 : shift[7];
      end
    end else if (grant.start) begin
      count <= `FLASH_XFER_CYCLES;
      shift <= grant.data;
      si_q  <= grant.data[7];
    end
  end

  assign busy      = count[7];
  assign rdata     = shift;
  assign pins.cs_n = ~cs_sel;
  assign pins.sck  = count[3];
  assign pins.si   = si_q;

endmodule

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f trs_io_top.f --top-module trs_io_top_tb -o trs_io_sim

out=$(./obj_dir/trs_io_sim 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "test passed"; then
  exit 0
fi
exit 1

/* trs_io_consts.svh */
`ifndef TRS_IO_CONSTS_SVH
`define TRS_IO_CONSTS_SVH

// reply to get_cookie, fixed marker the ESP looks for
`define TRS_IO_COOKIE 8'hAF

// major in [7:5], minor in [4:0]
`define TRS_IO_VERSION_MAJOR 3'd0
`define TRS_IO_VERSION_MINOR 5'd3
`define TRS_IO_VERSION {`TRS_IO_VERSION_MAJOR, `TRS_IO_VERSION_MINOR}

// z80 i/o ports of the config flash
`define FLASH_CTRL_PORT 8'hFC
`define FLASH_DATA_PORT 8'hFD

// clocks per flash byte, 8 sck periods of 16 clk
// loaded straight into the master counter, so its top bit is busy
`define FLASH_XFER_CYCLES 8'd128

// synchronizer stages on the esp spi pins
`define SYNC_DEPTH 3

`endif

/* trs_io_top.f */
+incdir+.
esp_link_pkg.sv
flash_pkg.sv
esp_spi_slave.sv
esp_cmd_parser.sv
z80_io_port.sv
flash_arbiter.sv
flash_spi_master.sv
trs_io_top.sv
trs_io_top_tb.sv

/* trs_io_top.sv */
`timescale 1ns/1ps

module trs_io_top (
  input  logic                   clk,
  input  logic                   cass_out_sel_n,
  input  logic                   esp_cs_n,
  input  logic                   esp_sck,
  input  logic                   esp_mosi,
  output logic                   esp_miso,
  input  flash_pkg::z80_io_t     z80_io,
  output logic [7:0]             io_rdata,
  output esp_link_pkg::led_rgb_t led,
  output logic                   err_led,
  output flash_pkg::flash_pins_t flash,
  input  logic                   flash_so
);

  import esp_link_pkg::*;
  import flash_pkg::*;

  logic [7:0] esp_byte;
  logic       esp_byte_valid;
  logic [7:0] esp_reply;
  esp_cmd_t   esp_cmd;
  logic       esp_cmd_valid;
  flash_req_t z80_req;
  flash_req_t grant;
  logic       flash_busy;
  logic [7:0] flash_rdata;

  esp_spi_slave u_spi_slave (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .cs_n           (esp_cs_n),
    .sck            (esp_sck),
    .mosi           (esp_mosi),
    .miso           (esp_miso),
    .reply          (esp_reply),
    .byte_in        (esp_byte),
    .byte_valid     (esp_byte_valid)
  );

  esp_cmd_parser u_parser (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .byte_in        (esp_byte),
    .byte_valid     (esp_byte_valid),
    .flash_rdata    (flash_rdata),
    .reply          (esp_reply),
    .cmd            (esp_cmd),
    .cmd_valid      (esp_cmd_valid),
    .led            (led),
    .err_led        (err_led)
  );

  z80_io_port u_z80_port (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .bus            (z80_io),
    .flash_rdata    (flash_rdata),
    .req            (z80_req),
    .io_rdata       (io_rdata)
  );

  flash_arbiter u_arbiter (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .z80_req        (z80_req),
    .esp_cmd        (esp_cmd),
    .esp_cmd_valid  (esp_cmd_valid),
    .flash_busy     (flash_busy),
    .grant          (grant)
  );

  flash_spi_master u_flash (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .grant          (grant),
    .so             (flash_so),
    .pins           (flash),
    .busy           (flash_busy),
    .rdata          (flash_rdata)
  );

endmodule

/* trs_io_top_tb.sv */
`timescale 1ns/1ps
`include "trs_io_consts.svh"

module trs_io_top_tb;

  import esp_link_pkg::*;
  import flash_pkg::*;

  // run length budget in clocks
  localparam int SPI_BYTES       = 19;
  localparam int FLASH_XFERS     = 3;
  localparam int WATCHDOG_CYCLES = 2 * (SPI_BYTES * 110 + FLASH_XFERS * 140);

  logic        clk;
  logic        cass_out_sel_n;
  logic        esp_cs_n;
  logic        esp_sck;
  logic        esp_mosi;
  logic        esp_miso;
  z80_io_t     z80_io;
  logic [7:0]  io_rdata;
  led_rgb_t    led;
  logic        err_led;
  flash_pins_t flash;
  logic        flash_so;

  logic [15:0] stim_lfsr;
  logic [15:0] model_lfsr;
  logic [7:0]  so_byte;
  logic [7:0]  si_byte;
  logic [2:0]  fall_cnt;
  int          pulse_total;
  int          err_count;
  logic [7:0]  si_log[$];
  logic [7:0]  so_log[$];

  trs_io_top dut (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .esp_cs_n       (esp_cs_n),
    .esp_sck        (esp_sck),
    .esp_mosi       (esp_mosi),
    .esp_miso       (esp_miso),
    .z80_io         (z80_io),
    .io_rdata       (io_rdata),
    .led            (led),
    .err_led        (err_led),
    .flash          (flash),
    .flash_so       (flash_so)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // taps 16, 14, 13, 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic rand_byte(output logic [7:0] val);
    int i;
    for (i = 0; i < 8; i++) begin
      stim_lfsr = lfsr_next(stim_lfsr);
      val = {val[6:0], stim_lfsr[0]};
    end
  endtask

  task automatic check_equal(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    if (exp !== act) begin
      err_count++;
      $display("ERR %s expected %0h actual %0h", name, exp, act);
      $display("test failed");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  // one esp spi byte in mode 0 with half phases of 6 clocks
  task automatic esp_xfer(input logic [7:0] tx, output logic [7:0] rx);
    int i;
    esp_cs_n = 1'b0;
    for (i = 7; i >= 0; i--) begin
      esp_mosi = tx[i];
      esp_sck  = 1'b0;
      repeat (6) @(negedge clk);
      if (i < 7) begin
        rx[i+1] = esp_miso;
      end
      esp_sck = 1'b1;
      repeat (6) @(negedge clk);
    end
    // trailing low half brings out the last reply bit
    esp_sck = 1'b0;
    repeat (6) @(negedge clk);
    rx[0]    = esp_miso;
    esp_cs_n = 1'b1;
    repeat (4) @(negedge clk);
  endtask

  task automatic z80_write(input logic [7:0] addr, input logic [7:0] data);
    z80_io.addr  = addr;
    z80_io.wdata = data;
    z80_io.wr_n  = 1'b0;
    repeat (2) @(negedge clk);
    z80_io.wr_n = 1'b1;
    @(negedge clk);
  endtask

  task automatic z80_read(input logic [7:0] addr, output logic [7:0] data);
    z80_io.addr = addr;
    z80_io.rd_n = 1'b0;
    @(negedge clk);
    data        = io_rdata;
    z80_io.rd_n = 1'b1;
    @(negedge clk);
  endtask

  task automatic wait_transfers(input int n);
    while (si_log.size() < n) begin
      @(negedge clk);
    end
  endtask

  task automatic load_so_byte();
    int i;
    for (i = 0; i < 8; i++) begin
      model_lfsr = lfsr_next(model_lfsr);
      so_byte = {so_byte[6:0], model_lfsr[0]};
    end
    flash_so = so_byte[7];
    fall_cnt = 3'd0;
  endtask

  // flash model with a fresh random so byte for every transfer
  initial begin
    logic sck_prev;
    logic cs_prev;
    flash_so    = 1'b0;
    model_lfsr  = 16'd40591;
    so_byte     = 8'h00;
    si_byte     = 8'h00;
    pulse_total = 0;
    sck_prev    = 1'b0;
    cs_prev     = 1'b1;
    load_so_byte();
    forever begin
      @(negedge clk);
      if (!sck_prev && flash.sck) begin
        si_byte = {si_byte[6:0], flash.si};
        pulse_total++;
      end
      if (cs_prev && !flash.cs_n) begin
        load_so_byte();
      end else if (sck_prev && !flash.sck) begin
        if (fall_cnt == 3'd7) begin
          si_log.push_back(si_byte);
          so_log.push_back(so_byte);
          load_so_byte();
        end else begin
          fall_cnt = fall_cnt + 3'd1;
          flash_so = so_byte[3'd7 - fall_cnt];
        end
      end
      sck_prev = flash.sck;
      cs_prev  = flash.cs_n;
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("test failed");
    $fatal(1, "watchdog timeout, run exceeded %0d clocks", WATCHDOG_CYCLES);
  end

  initial begin
    logic [7:0] r;
    logic [7:0] p;
    logic [7:0] q;
    logic [7:0] z;
    logic [7:0] z2;
    int         base;
    int         base_p;
    stim_lfsr      = 16'd40591;
    err_count      = 0;
    cass_out_sel_n = 1'b0;
    esp_cs_n       = 1'b1;
    esp_sck        = 1'b0;
    esp_mosi       = 1'b0;
    z80_io.addr    = 8'h00;
    z80_io.rd_n    = 1'b1;
    z80_io.wr_n    = 1'b1;
    z80_io.wdata   = 8'h00;
    repeat (5) @(negedge clk);
    cass_out_sel_n = 1'b1;
    @(negedge clk);
    check_equal("reset flash pins", 32'h4, 32'(flash));
    check_equal("reset led", 32'h0, 32'(led));
    check_equal("reset err_led", 32'h0, 32'(err_led));
    check_equal("reset miso", 32'h0, 32'(esp_miso));

    // getters answer during the following byte
    esp_xfer(get_cookie, r);
    esp_xfer(8'h00, r);
    check_equal("get_cookie", 32'hAF, 32'(r));
    esp_xfer(get_version, r);
    esp_xfer(8'h00, r);
    check_equal("get_version", 32'h03, 32'(r));

    rand_byte(p);
    esp_xfer(set_led, r);
    esp_xfer(p, r);
    check_equal("set_led", 32'(p[2:0]), 32'(led));
    check_equal("err_led clear", 32'h0, 32'(err_led));
    rand_byte(q);
    if (q <= 8'd32) begin
      q = q | 8'h80;
    end
    esp_xfer(q, r);
    check_equal("unknown opcode", 32'h1, 32'(err_led));
    esp_xfer(get_cookie, r);
    esp_xfer(8'h00, r);
    check_equal("cookie after error", 32'hAF, 32'(r));
    check_equal("err_led sticky", 32'h1, 32'(err_led));

    // chip select follows control bit 7 from either peer
    rand_byte(p);
    esp_xfer(set_spi_ctrl_reg, r);
    esp_xfer(p, r);
    check_equal("esp ctrl cs_n", 32'(!p[7]), 32'(flash.cs_n));
    rand_byte(q);
    z80_write(`FLASH_CTRL_PORT, q);
    check_equal("z80 ctrl cs_n", 32'(!q[7]), 32'(flash.cs_n));

    esp_xfer(set_spi_ctrl_reg, r);
    esp_xfer(8'h80, r);
    check_equal("flash selected", 32'h0, 32'(flash.cs_n));
    base   = si_log.size();
    base_p = pulse_total;
    rand_byte(p);
    esp_xfer(set_spi_data, r);
    esp_xfer(p, r);
    wait_transfers(base + 1);
    check_equal("esp sck pulses", 32'd8, pulse_total - base_p);
    check_equal("esp si byte", 32'(p), 32'(si_log[base]));
    esp_xfer(get_spi_data, r);
    esp_xfer(8'h00, r);
    check_equal("get_spi_data", 32'(so_log[base]), 32'(r));
    z80_read(`FLASH_DATA_PORT, q);
    check_equal("z80 data read", 32'(so_log[base]), 32'(q));
    check_equal("idle io_rdata", 32'hFF, 32'(io_rdata));

    // esp byte lands while the z80 transfer runs and gets parked
    base   = si_log.size();
    base_p = pulse_total;
    rand_byte(z);
    rand_byte(p);
    z2 = ~p;
    esp_xfer(set_spi_data, r);
    z80_write(`FLASH_DATA_PORT, z);
    fork
      esp_xfer(p, r);
      begin
        repeat (40) @(negedge clk);
        z80_write(`FLASH_DATA_PORT, z2);
      end
    join
    wait_transfers(base + 2);
    // long enough for a whole third byte to show up
    repeat (`FLASH_XFER_CYCLES + 16) @(negedge clk);
    check_equal("transfer count", 32'(base + 2), 32'(si_log.size()));
    check_equal("busy sck pulses", 32'd16, pulse_total - base_p);
    check_equal("z80 si byte", 32'(z), 32'(si_log[base]));
    check_equal("parked esp si byte", 32'(p), 32'(si_log[base + 1]));

    if (err_count == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

/* z80_io_port.sv */
`timescale 1ns/1ps
`include "trs_io_consts.svh"

module z80_io_port (
  input  logic                 clk,
  input  logic                 cass_out_sel_n,
  input  flash_pkg::z80_io_t   bus,
  input  logic [7:0]           flash_rdata,
  output flash_pkg::flash_req_t req,
  output logic [7:0]           io_rdata
);

  logic wr_n_q;
  logic wr_start;

  // write strobe just went low
  assign wr_start = wr_n_q & ~bus.wr_n;

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      wr_n_q <= 1'b1;
      req    <= '0;
    end else begin
      wr_n_q      <= bus.wr_n;
      req.ctrl_wr <= wr_start && (bus.addr == `FLASH_CTRL_PORT);
      req.start   <= wr_start && (bus.addr == `FLASH_DATA_PORT);
      req.data    <= bus.wdata;
    end
  end

  // data port reads the shift register, anything else floats high
  always_comb begin
    if (!bus.rd_n && (bus.addr == `FLASH_DATA_PORT)) begin
      io_rdata = flash_rdata;
    end else begin
      io_rdata = 8'hFF;
    end
  end

endmodule
